/* source/nes_bus_pkg.sv */
////////////////////////////////////////////////////////////
// Widths, register addresses and DMA constants shared by the
// CPU-side bus RTL and its testbench, used by scoped names
////////////////////////////////////////////////////////////
`default_nettype none

package nes_bus_pkg;

	// Bus word types
	typedef logic [15:0] addr_t;    // CPU address bus
	typedef logic [7:0]  data_t;    // CPU data bus

	// Sprite DMA trigger, CPU writes the source page here
	localparam addr_t SPRITE_DMA_REG = 16'h4014;

	// PPU sprite memory data port, every sprite DMA write lands here
	localparam addr_t OAM_DATA_REG = 16'h2004;

	// Joypad ports
	// Write to JOY1_REG sets the three strobe bits
	// Read of either port clocks that pad
	localparam addr_t JOY1_REG = 16'h4016;
	localparam addr_t JOY2_REG = 16'h4017;

	// I/O window, never decoded as memory
	localparam addr_t IO_FIRST = 16'h4000;
	localparam addr_t IO_LAST  = 16'h4017;   // Inclusive

	// One page per sprite DMA
	localparam int SPRITE_BYTES = 256;

	// Master clocks per CPU cycle
	// NTSC console runs the CPU at master / 12
	localparam int CPU_DIV_DEFAULT = 12;

endpackage

`default_nettype wire

/* source/cpu_clock_divider.sv */
////////////////////////////////////////////////////////////
// CPU clock enable, odd/even cycle flag and the stretched
// reset that releases both DMA engines on a CPU edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cpu_clock_divider #(
	parameter int cpu_div = nes_bus_pkg::CPU_DIV_DEFAULT
) (
	input  wire  clk,
	input  wire  reset,
	output logic cpu_ce,      // One clock in every cpu_div
	output logic odd_cycle,   // 1 = odd CPU cycle
	output logic dma_reset    // Held until first CPU edge
);

	localparam int cnt_w = $clog2(cpu_div);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(cpu_div - 1);

	logic [cnt_w-1:0] div_cnt;

	// Enable on the last count of each CPU cycle
	assign cpu_ce = (div_cnt == cnt_last);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0;    // Wrap
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Parity starts odd so the first CPU cycle after reset is even
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b1;
			dma_reset <= 1'b1;
		end else if (cpu_ce) begin
			odd_cycle <= ~odd_cycle;
			dma_reset <= 1'b0;   // Engines leave reset together
		end
	end

	// Strobe never lasts more than one clock
	a_ce_single: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce);

endmodule

`default_nettype wire

/* source/sprite_dma.sv */
////////////////////////////////////////////////////////////
// Sprite DMA engine, copies one 256-byte page to the sprite
// memory port after a CPU write to the trigger register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sprite_dma (
	input  wire                     clk,
	input  wire                     cpu_ce,
	input  wire                     dma_reset,
	input  wire                     odd_cycle,
	input  wire                     trigger,      // CPU write to $4014
	input  wire nes_bus_pkg::data_t page,         // Source page from the CPU
	input  wire                     cpu_rnw,
	input  wire                     dmc_active,   // DMC owns this even cycle
	input  wire nes_bus_pkg::data_t rdata,        // Byte read on the bus
	output logic                    spr_pending,  // Armed, CPU must stall
	output logic                    spr_active,   // Transfer phase
	output nes_bus_pkg::addr_t      spr_addr,     // Source byte address
	output nes_bus_pkg::data_t      spr_data      // Byte for the next write
);

	// Bit 0 stalls the CPU, bit 1 owns the bus
	localparam logic [1:0] st_idle  = 2'b00;
	localparam logic [1:0] st_armed = 2'b01;
	localparam logic [1:0] st_xfer  = 2'b11;

	localparam logic [7:0] last_byte = 8'(nes_bus_pkg::SPRITE_BYTES - 1);

	logic [1:0] state;

	assign spr_pending = state[0];
	assign spr_active  = state[1];

	always_ff @(posedge clk) begin
		if (dma_reset) begin
			state <= st_idle;
		end else if (cpu_ce) begin
			case (state)
				st_idle: begin
					if (trigger) begin
						state <= st_armed;
					end
				end
				st_armed: begin
					// Start on an odd read cycle, first transfer cycle is even
					if (cpu_rnw && odd_cycle) begin
						state <= st_xfer;
					end
				end
				st_xfer: begin
					if (!odd_cycle && dmc_active) begin
						state <= st_armed;   // Read stolen, redo on next even
					end else if (odd_cycle && spr_addr[7:0] == last_byte) begin
						state <= st_idle;    // Low byte wraps
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Source address and read latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (state == st_idle && trigger) begin
				spr_addr <= {page, 8'h00};
			end else if (spr_active && odd_cycle) begin
				spr_addr[7:0] <= spr_addr[7:0] + 8'h01;   // Next byte after each write
			end
			if (spr_active && !odd_cycle && !dmc_active) begin
				spr_data <= rdata;    // Written on the following odd cycle
			end
		end
	end

	// Transfer phase only inside the stall window
	a_active_pending: assert property (@(posedge clk) disable iff (dma_reset)
		spr_active |-> spr_pending);

endmodule

`default_nettype wire

/* source/dmc_dma.sv */
////////////////////////////////////////////////////////////
// Sample fetch engine, takes the sound unit's request and
// steals one even CPU cycle for a single byte read
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dmc_dma (
	input  wire  clk,
	input  wire  cpu_ce,
	input  wire  dma_reset,
	input  wire  odd_cycle,
	input  wire  dmc_req,      // Held until the acknowledge
	input  wire  cpu_rnw,
	output logic dmc_active    // Fetch cycle, one CPU cycle long
);

	logic fetch_armed;    // Request taken, waiting for the next even cycle

	// Fetch runs only in the even half of the pair
	assign dmc_active = fetch_armed && !odd_cycle;

	always_ff @(posedge clk) begin
		if (dma_reset) begin
			fetch_armed <= 1'b0;
		end else if (cpu_ce) begin
			if (!fetch_armed) begin
				// Only taken on an even read cycle
				if (dmc_req && cpu_rnw && !odd_cycle) begin
					fetch_armed <= 1'b1;
				end
			end else if (!odd_cycle) begin
				fetch_armed <= 1'b0;   // Fetch done at end of even cycle
			end
		end
	end

	// Fetch cycle is followed by an odd cycle with no fetch
	a_fetch_once: assert property (@(posedge clk) disable iff (dma_reset)
		(cpu_ce && dmc_active) |=> (odd_cycle && !dmc_active));

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
////////////////////////////////////////////////////////////
// Bus master select by fixed priority DMC, sprite DMA, CPU
// and the CPU stall that goes with it
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  wire                     dmc_active,
	input  wire                     dmc_req,
	input  wire nes_bus_pkg::addr_t dmc_addr,
	input  wire                     spr_pending,
	input  wire                     spr_active,
	input  wire nes_bus_pkg::addr_t spr_addr,
	input  wire nes_bus_pkg::data_t spr_data,
	input  wire                     odd_cycle,
	input  wire nes_bus_pkg::addr_t cpu_addr,
	input  wire nes_bus_pkg::data_t cpu_wdata,
	input  wire                     cpu_rnw,
	output nes_bus_pkg::addr_t      bus_addr,
	output nes_bus_pkg::data_t      bus_wdata,
	output logic                    bus_read,
	output logic                    bus_write,
	output logic                    pause_cpu,
	output logic                    dmc_ack
);

	// CPU holds its cycle while either engine wants the bus
	assign pause_cpu = spr_pending || dmc_req;
	assign dmc_ack   = dmc_active;    // Byte is on cpu_rdata this cycle

	always_comb begin
		// CPU by default, access only goes out when not stalled
		bus_addr  = cpu_addr;
		bus_wdata = cpu_wdata;
		bus_read  = cpu_rnw && !pause_cpu;
		bus_write = !cpu_rnw && !pause_cpu;

		if (dmc_active) begin
			bus_addr  = dmc_addr;     // Sample byte fetch
			bus_read  = 1'b1;
			bus_write = 1'b0;
		end else if (spr_active) begin
			// Even reads the page, odd writes to sprite memory
			bus_wdata = spr_data;
			bus_read  = !odd_cycle;
			bus_write = odd_cycle;
			if (odd_cycle) begin
				bus_addr = nes_bus_pkg::OAM_DATA_REG;
			end else begin
				bus_addr = spr_addr;
			end
		end
	end

	// One direction per cycle
	always_comb begin
		a_one_dir: assert final (!(bus_read && bus_write));
	end

endmodule

`default_nettype wire

/* source/io_decode.sv */
////////////////////////////////////////////////////////////
// I/O window decode, joypad strobe latch, open bus and the
// read data mux back to the CPU
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module io_decode (
	input  wire                     clk,
	input  wire                     cpu_ce,
	input  wire                     reset,
	input  wire nes_bus_pkg::addr_t bus_addr,
	input  wire nes_bus_pkg::data_t bus_wdata,
	input  wire                     bus_read,
	input  wire                     bus_write,
	input  wire nes_bus_pkg::data_t mem_rdata,
	input  wire [4:0]               joypad1_data,   // Port 1 serial bits
	input  wire [4:0]               joypad2_data,   // Port 2 serial bits
	output logic                    sprite_trigger,
	output logic                    mem_read,
	output logic                    mem_write,
	output nes_bus_pkg::data_t      cpu_rdata,
	output logic [2:0]              joypad_out,     // Strobe bits
	output logic [1:0]              joypad_clock    // One bit per pad
);

	logic io_sel;      // $4000-$4017
	logic joy1_sel;
	logic joy2_sel;
	logic trig_sel;

	nes_bus_pkg::data_t open_bus;    // Last value on the data bus

	assign io_sel = (bus_addr >= nes_bus_pkg::IO_FIRST) &&
		(bus_addr <= nes_bus_pkg::IO_LAST);
	assign joy1_sel = (bus_addr == nes_bus_pkg::JOY1_REG);
	assign joy2_sel = (bus_addr == nes_bus_pkg::JOY2_REG);
	assign trig_sel = (bus_addr == nes_bus_pkg::SPRITE_DMA_REG);

	// Memory sees everything outside the I/O window
	assign mem_read  = bus_read && !io_sel;
	assign mem_write = bus_write && !io_sel;

	assign sprite_trigger = bus_write && trig_sel;   // Sampled on the CPU edge

	// Pad shifts on a read of its own port
	assign joypad_clock = {bus_read && joy2_sel, bus_read && joy1_sel};

	// Read data mux
	always_comb begin
		if (bus_read && joy1_sel) begin
			cpu_rdata = {open_bus[7:5], joypad1_data};   // Upper bits float
		end else if (bus_read && joy2_sel) begin
			cpu_rdata = {open_bus[7:5], joypad2_data};
		end else if (mem_read) begin
			cpu_rdata = mem_rdata;
		end else begin
			cpu_rdata = open_bus;     // Nothing answers
		end
	end

	// Strobe latch
	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_out <= 3'b000;
		end else if (cpu_ce && bus_write && joy1_sel) begin
			joypad_out <= bus_wdata[2:0];
		end
	end

	// Bus keeps its last value, idle and write cycles just hold it
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			open_bus <= cpu_rdata;
		end
	end

endmodule

`default_nettype wire

/* source/nes_cpu_bus.sv */
////////////////////////////////////////////////////////////
// CPU-side system bus top, joins the clock divider, both
// DMA engines, the arbiter and the I/O decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module nes_cpu_bus #(
	parameter int cpu_div = nes_bus_pkg::CPU_DIV_DEFAULT
) (
	input  wire                     clk,
	input  wire                     reset,
	input  wire nes_bus_pkg::addr_t cpu_addr,
	input  wire nes_bus_pkg::data_t cpu_wdata,
	input  wire                     cpu_rnw,
	output wire                     cpu_ce,
	output wire                     pause_cpu,
	output wire nes_bus_pkg::data_t cpu_rdata,
	input  wire                     dmc_req,
	input  wire nes_bus_pkg::addr_t dmc_addr,
	output wire                     dmc_ack,
	output wire nes_bus_pkg::addr_t mem_addr,
	output wire                     mem_read,
	output wire                     mem_write,
	output wire nes_bus_pkg::data_t mem_wdata,
	input  wire nes_bus_pkg::data_t mem_rdata,
	input  wire [4:0]               joypad1_data,
	input  wire [4:0]               joypad2_data,
	output wire [2:0]               joypad_out,
	output wire [1:0]               joypad_clock
);

	wire                     odd_cycle;
	wire                     dma_reset;
	wire                     sprite_trigger;
	wire                     spr_pending;
	wire                     spr_active;
	wire nes_bus_pkg::addr_t spr_addr;
	wire nes_bus_pkg::data_t spr_data;
	wire                     dmc_active;
	wire nes_bus_pkg::addr_t bus_addr;    // Granted master's address
	wire nes_bus_pkg::data_t bus_wdata;
	wire                     bus_read;
	wire                     bus_write;

	assign mem_addr  = bus_addr;
	assign mem_wdata = bus_wdata;

	cpu_clock_divider #(.cpu_div(cpu_div)) u_clk_div (
		.clk(clk), .reset(reset), .cpu_ce(cpu_ce), .odd_cycle(odd_cycle),
		.dma_reset(dma_reset)
	);

	// Page comes straight off the write data of the trigger cycle
	sprite_dma u_sprite_dma (
		.clk(clk), .cpu_ce(cpu_ce), .dma_reset(dma_reset), .odd_cycle(odd_cycle),
		.trigger(sprite_trigger), .page(bus_wdata), .cpu_rnw(cpu_rnw),
		.dmc_active(dmc_active), .rdata(cpu_rdata), .spr_pending(spr_pending),
		.spr_active(spr_active), .spr_addr(spr_addr), .spr_data(spr_data)
	);

	dmc_dma u_dmc_dma (
		.clk(clk), .cpu_ce(cpu_ce), .dma_reset(dma_reset), .odd_cycle(odd_cycle),
		.dmc_req(dmc_req), .cpu_rnw(cpu_rnw), .dmc_active(dmc_active)
	);

	bus_arbiter u_arbiter (
		.dmc_active(dmc_active), .dmc_req(dmc_req), .dmc_addr(dmc_addr),
		.spr_pending(spr_pending), .spr_active(spr_active), .spr_addr(spr_addr),
		.spr_data(spr_data), .odd_cycle(odd_cycle), .cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata), .cpu_rnw(cpu_rnw), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_read(bus_read), .bus_write(bus_write),
		.pause_cpu(pause_cpu), .dmc_ack(dmc_ack)
	);

	// Strobe latch leaves reset with the engines
	io_decode u_io_decode (
		.clk(clk), .cpu_ce(cpu_ce), .reset(dma_reset), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_read(bus_read), .bus_write(bus_write),
		.mem_rdata(mem_rdata), .joypad1_data(joypad1_data),
		.joypad2_data(joypad2_data), .sprite_trigger(sprite_trigger),
		.mem_read(mem_read), .mem_write(mem_write), .cpu_rdata(cpu_rdata),
		.joypad_out(joypad_out), .joypad_clock(joypad_clock)
	);

endmodule

`default_nettype wire

/* sim/bus_tests.svh */
////////////////////////////////////////////////////////////
// Directed tests for the CPU-side bus, included in the body
// of the testbench top and called from its main sequence
////////////////////////////////////////////////////////////
`ifndef BUS_TESTS_SVH
`define BUS_TESTS_SVH

// Nothing stalled, no strobes, strobe latch clear
task automatic check_quiet_outputs(input string when_seen);
	check_that(pause_cpu === 1'b0 && dmc_ack === 1'b0 && mem_write === 1'b0 &&
		joypad_clock === 2'b00 && joypad_out === 3'b000,
		$sformatf("outputs not quiet %s, pause %b ack %b write %b jclk %b jout %b",
		when_seen, pause_cpu, dmc_ack, mem_write, joypad_clock, joypad_out));
endtask

// Reset is high from time 0, held for 16 clocks
task automatic check_reset_state();
	int errors_before;
	errors_before = errors;
	repeat (15) @(posedge clk);
	#1 check_quiet_outputs("during reset");
	@(posedge clk);
	#1 reset = 1'b0;
	repeat (2) begin
		wait_ce_cycle();
		pass_ce();
	end
	check_quiet_outputs("after reset");
	report_test("reset", errors_before);
endtask

// Odd flag is 1 out of reset and flips on every CPU edge
task automatic check_dmc_cycle(input nes_bus_pkg::addr_t addr);
	check_that(ce_count[0] === 1'b1, $sformatf("DMC acknowledge after %0d edges", ce_count));
	check_that(mem_read === 1'b1 && mem_addr === addr,
		$sformatf("DMC fetch read %b at %h, expected 1 at %h", mem_read, mem_addr, addr));
	check_that(cpu_rdata === mem[addr],
		$sformatf("DMC byte %h, expected %h", cpu_rdata, mem[addr]));
endtask

task automatic fetch_dmc_sample(input nes_bus_pkg::addr_t addr);
	int   errors_before;
	int   acks;
	logic acked;
	errors_before = errors;
	acks          = 0;
	dmc_addr      = addr;
	dmc_req       = 1'b1;
	repeat (dmc_cycles) begin
		wait_ce_cycle();
		acked = dmc_ack;
		if (acked === 1'b1) begin
			acks++;
			check_dmc_cycle(addr);
		end
		pass_ce();
		if (acked === 1'b1) dmc_req = 1'b0;   // Let go after the acknowledge edge
	end
	check_that(acks == 1, $sformatf("%0d DMC acknowledges, expected 1", acks));
	check_that(pause_cpu === 1'b0, "CPU still stalled after the DMC fetch");
	report_test("DMC fetch", errors_before);
endtask

// Page copy, with a DMC request raised steal_at cycles in when steal_at >= 0
task automatic copy_page_to_oam(input string name, input nes_bus_pkg::data_t page,
	input int steal_at, input nes_bus_pkg::addr_t steal_addr);
	nes_bus_pkg::data_t expect_bytes [nes_bus_pkg::SPRITE_BYTES];
	nes_bus_pkg::data_t rd;
	int                 errors_before;
	int                 n;
	int                 acks;
	int                 steal_reads;
	logic               acked;
	errors_before = errors;
	for (int i = 0; i < nes_bus_pkg::SPRITE_BYTES; i++) begin
		expect_bytes[i] = mem[{page, 8'(i)}];    // Source page before the copy
	end
	wr_addr_log.delete();
	wr_data_log.delete();
	acks        = 0;
	steal_reads = 0;
	n           = 0;
	cpu_cycle(nes_bus_pkg::SPRITE_DMA_REG, 1'b0, page, rd);
	check_that(pause_cpu === 1'b1, "CPU not stalled after the $4014 write");
	while (pause_cpu === 1'b1 && n < dma_cycles) begin
		if (n == steal_at) begin
			dmc_addr = steal_addr;
			dmc_req  = 1'b1;
		end
		wait_ce_cycle();
		acked = dmc_ack;
		if (steal_at >= 0 && mem_read === 1'b1 && mem_addr === steal_addr) steal_reads++;
		if (acked === 1'b1) begin
			acks++;
			check_dmc_cycle(steal_addr);
		end
		pass_ce();
		if (acked === 1'b1) dmc_req = 1'b0;
		n++;
	end
	checks++;
	assert (pause_cpu === 1'b0) else begin
		$display("Sprite DMA still stalls the CPU after %0d CPU cycles", n);
		errors++;
	end
	// Stall ends with the last write already in the log
	check_that(wr_addr_log.size() == nes_bus_pkg::SPRITE_BYTES, $sformatf(
		"%0d writes logged, expected %0d", wr_addr_log.size(), nes_bus_pkg::SPRITE_BYTES));
	for (int i = 0; i < wr_addr_log.size() && i < nes_bus_pkg::SPRITE_BYTES; i++) begin
		check_that(wr_addr_log[i] === nes_bus_pkg::OAM_DATA_REG &&
			wr_data_log[i] === expect_bytes[i], $sformatf("write %0d is %h to %h, expected %h",
			i, wr_data_log[i], wr_addr_log[i], expect_bytes[i]));
	end
	if (steal_at >= 0) begin
		check_that(acks == 1, $sformatf("%0d DMC acknowledges, expected 1", acks));
		check_that(steal_reads == 1, $sformatf("DMC byte read %0d times", steal_reads));
	end
	report_test(name, errors_before);
endtask

task automatic exercise_joypads();
	nes_bus_pkg::data_t v;
	nes_bus_pkg::data_t rd;
	nes_bus_pkg::data_t expect_rd;
	int                 errors_before;
	errors_before = errors;
	v             = 8'hfd;
	joypad1_data  = 5'h15;
	joypad2_data  = 5'h0a;
	cpu_cycle(nes_bus_pkg::JOY1_REG, 1'b0, v, rd);
	check_that(joypad_out === v[2:0], $sformatf("strobe %b, expected %b", joypad_out, v[2:0]));
	cpu_cycle(16'h0123, 1'b1, 8'h00, rd);       // Leaves a known byte on the bus
	expect_rd = {mem[16'h0123][7:5], joypad1_data};
	cpu_cycle(nes_bus_pkg::JOY1_REG, 1'b1, 8'h00, rd);
	check_that(rd === expect_rd && last_joypad_clock === 2'b01, $sformatf(
		"pad 1 read %h clock %b, expected %h clock 01", rd, last_joypad_clock, expect_rd));
	expect_rd = {expect_rd[7:5], joypad2_data};
	cpu_cycle(nes_bus_pkg::JOY2_REG, 1'b1, 8'h00, rd);
	check_that(rd === expect_rd && last_joypad_clock === 2'b10, $sformatf(
		"pad 2 read %h clock %b, expected %h clock 10", rd, last_joypad_clock, expect_rd));
	report_test("joypads", errors_before);
endtask

task automatic read_open_bus();
	nes_bus_pkg::data_t b;
	nes_bus_pkg::data_t rd;
	int                 errors_before;
	errors_before = errors;
	b             = mem[16'h0456];
	cpu_cycle(16'h0456, 1'b1, 8'h00, rd);
	check_that(rd === b, $sformatf("memory read %h, expected %h", rd, b));
	cpu_cycle(16'h4000, 1'b1, 8'h00, rd);       // Nothing answers here
	check_that(rd === b && last_mem_read === 1'b0, $sformatf(
		"$4000 read %h with mem_read %b, expected %h and 0", rd, last_mem_read, b));
	report_test("open bus", errors_before);
endtask

`endif

/* sim/tb_nes_cpu_bus.sv */
////////////////////////////////////////////////////////////
// Testbench for the CPU-side bus, drives CPU, DMC and joypad
// ports against a 64 KB memory model and runs the directed tests
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_nes_cpu_bus;

	localparam int cpu_div = nes_bus_pkg::CPU_DIV_DEFAULT;

	// Worst case CPU cycles per test, sizes the watchdog
	localparam int dma_cycles   = 600;     // 512 plus steals and start
	localparam int dmc_cycles   = 16;
	localparam int total_cycles = 4 + 2 * (dma_cycles + 2) + dmc_cycles + 8;

	logic                      clk;
	logic                      reset;
	nes_bus_pkg::addr_t        cpu_addr;
	nes_bus_pkg::data_t        cpu_wdata;
	logic                      cpu_rnw;
	logic                      dmc_req;
	nes_bus_pkg::addr_t        dmc_addr;
	logic [4:0]                joypad1_data;
	logic [4:0]                joypad2_data;
	wire                       cpu_ce;
	wire                       pause_cpu;
	wire nes_bus_pkg::data_t   cpu_rdata;
	wire                       dmc_ack;
	wire nes_bus_pkg::addr_t   mem_addr;
	wire                       mem_read;
	wire                       mem_write;
	wire nes_bus_pkg::data_t   mem_wdata;
	wire nes_bus_pkg::data_t   mem_rdata;
	wire [2:0]                 joypad_out;
	wire [1:0]                 joypad_clock;

	nes_bus_pkg::data_t mem [0:65535];      // Memory model
	nes_bus_pkg::addr_t wr_addr_log [$];    // Every memory write, in order
	nes_bus_pkg::data_t wr_data_log [$];
	integer             seed;
	int                 ce_count;           // CPU edges since reset
	int                 ce_gap;             // Clocks since the last CPU edge
	int                 errors;
	int                 checks;
	int                 tests_run;
	logic [1:0]         last_joypad_clock;  // Sampled in the last completed CPU cycle
	logic               last_mem_read;

	nes_cpu_bus #(.cpu_div(cpu_div)) UUT (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rnw(cpu_rnw), .cpu_ce(cpu_ce), .pause_cpu(pause_cpu), .cpu_rdata(cpu_rdata),
		.dmc_req(dmc_req), .dmc_addr(dmc_addr), .dmc_ack(dmc_ack), .mem_addr(mem_addr),
		.mem_read(mem_read), .mem_write(mem_write), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .joypad1_data(joypad1_data), .joypad2_data(joypad2_data),
		.joypad_out(joypad_out), .joypad_clock(joypad_clock)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Combinational read, write lands on the CPU edge
	assign mem_rdata = mem[mem_addr];

	always @(posedge clk) begin
		if (cpu_ce && mem_write) begin
			mem[mem_addr] <= mem_wdata;
			wr_addr_log.push_back(mem_addr);
			wr_data_log.push_back(mem_wdata);
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			ce_count <= 0;
		end else if (cpu_ce) begin
			ce_count <= ce_count + 1;
		end
	end

	// Returns 1 ns into the last clock of a CPU cycle
	task automatic wait_ce_cycle();
		while (cpu_ce !== 1'b1) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic pass_ce();
		@(posedge clk);
		#1;     // Next drive point
	endtask

	// One CPU bus cycle, repeated while the CPU is stalled
	task automatic cpu_cycle(input nes_bus_pkg::addr_t addr, input logic rnw,
		input nes_bus_pkg::data_t wdata, output nes_bus_pkg::data_t rdata);
		logic stalled;
		cpu_addr  = addr;
		cpu_rnw   = rnw;
		cpu_wdata = wdata;
		stalled   = 1'b1;
		while (stalled === 1'b1) begin
			wait_ce_cycle();
			stalled           = pause_cpu;
			rdata             = cpu_rdata;
			last_joypad_clock = joypad_clock;
			last_mem_read     = mem_read;
			pass_ce();
		end
		cpu_addr  = 16'h0000;    // Idle read
		cpu_rnw   = 1'b1;
		cpu_wdata = 8'h00;
	endtask

	task automatic check_that(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1) else begin
			$display("Fail %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("%-18s %s, %0d failed checks", name,
			(errors == errors_before) ? "passed" : "FAILED", errors - errors_before);
	endtask

	// Enable comes exactly once every cpu_div clocks
	always @(posedge clk) begin
		if (reset) begin
			ce_gap <= 0;
		end else if (cpu_ce) begin
			check_that(ce_gap == cpu_div - 1,
				$sformatf("cpu_ce after %0d clocks, expected %0d", ce_gap + 1, cpu_div));
			ce_gap <= 0;
		end else begin
			ce_gap <= ce_gap + 1;
		end
	end

	`include "bus_tests.svh"

	// Hang guard, twice the worst case length of all tests
	initial begin
		#(longint'(total_cycles) * cpu_div * 10 * 2);
		$display("Watchdog expired, a test stopped making progress");
		$display("Errors found");
		$finish;
	end

	initial begin
		seed              = 32'hd15e;
		errors            = 0;
		checks            = 0;
		tests_run         = 0;
		reset             = 1'b1;
		cpu_addr          = 16'h0000;
		cpu_wdata         = 8'h00;
		cpu_rnw           = 1'b1;
		dmc_req           = 1'b0;
		dmc_addr          = 16'h0000;
		joypad1_data      = 5'h00;
		joypad2_data      = 5'h00;
		last_joypad_clock = 2'b00;
		last_mem_read     = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'($random(seed));
		end
		check_reset_state();
		copy_page_to_oam("sprite DMA", 8'h03, -1, 16'h0000);
		fetch_dmc_sample(16'hc3a5);
		copy_page_to_oam("DMC in sprite DMA", 8'h05, 101, 16'h71c2);
		exercise_joypads();
		read_open_bus();
		$display("%0d tests, %0d checks, %0d failed", tests_run, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
source/nes_bus_pkg.sv
source/cpu_clock_divider.sv
source/sprite_dma.sv
source/dmc_dma.sv
source/bus_arbiter.sv
source/io_decode.sv
source/nes_cpu_bus.sv
sim/tb_nes_cpu_bus.sv
